//--- rtl/elink_cfg.sv
`timescale 1ns/1ps
`default_nettype none

// stage 2 of the tx write path
// decodes the config group, holds the link registers
// and strips register writes out of the tx stream
module elink_cfg
   import elink_pkg::*;
(
   input  wire      clk,
   input  wire      nreset,          // por hard reset
   input  wire      access_t s1,     // from emesh_unpack
   output tx_t      s2,              // to etx_gate
   output logic     etx_soft_reset,  // level
   output logic     erx_soft_reset,  // level
   output clk_cfg_t clk_config,      // to the pll
   output chipid_t  chipid
);

   // decode
   addr_t    mi_addr;
   data_t    mi_din;
   reg_idx_t mi_idx;
   logic     mi_en;          // access hits our group
   logic     mi_write;       // write into the group
   logic     reset_write;
   logic     clk_write;
   logic     chipid_write;
   logic     reg_write;      // any of the three registers

   // registers
   logic [1:0] reset_reg;    // [0] tx, [1] rx
   clk_cfg_t   clk_reg;
   chipid_t    chipid_reg;

   // stream out
   logic    tx_access_q;
   packet_t tx_packet_q;

   //########################################
   // address decode
   //########################################
   assign mi_addr = s1.pkt.dstaddr;
   assign mi_din  = s1.pkt.data;
   assign mi_idx  = mi_addr[rfaw+1:2];  // word index

   assign mi_en = s1.access &
                  (mi_addr[31:20] == elink_id) &
                  (mi_addr[10:8] == cfg_group);

   assign mi_write = mi_en & s1.pkt.write;  // reads fall through

   assign reset_write  = mi_write & (mi_idx == reg_reset);
   assign clk_write    = mi_write & (mi_idx == reg_clk);
   assign chipid_write = mi_write & (mi_idx == reg_chipid);

   // unused indices are not ours, they go on to the fifo
   assign reg_write = reset_write | clk_write | chipid_write;

   //########################################
   // soft reset register
   //########################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         reset_reg <= 2'b00;
      end else if (reset_write) begin
         reset_reg <= mi_din[1:0];
      end
   end

   assign etx_soft_reset = reset_reg[0];
   assign erx_soft_reset = reset_reg[1];  // exported only, rx not here

   //########################################
   // clock config register
   //########################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         clk_reg <= clk_cfg_default;
      end else if (clk_write) begin
         clk_reg <= mi_din[15:0];
      end
   end

   assign clk_config = clk_reg;

   // chip id
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         chipid_reg <= chipid_default;
      end else if (chipid_write) begin
         chipid_reg <= mi_din[11:0];
      end
   end

   assign chipid = chipid_reg;

   //########################################
   // stream filter
   //########################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         tx_access_q <= 1'b0;
      end else begin
         tx_access_q <= s1.access & ~reg_write;  // eat register writes
      end
   end

   // payload follows any valid access, filtered or not
   always_ff @(posedge clk) begin
      if (s1.access) begin
         tx_packet_q <= packet_t'(s1.pkt);  // back to raw bit order
      end
   end

   assign s2.access = tx_access_q;
   assign s2.packet = tx_packet_q;

endmodule

`default_nettype wire

//--- rtl/elink_pkg.sv
`default_nettype none

package elink_pkg;

   //########################################
   // widths
   //########################################
   localparam int pkt_w  = 104;  // emesh packet
   localparam int addr_w = 32;
   localparam int data_w = 32;
   localparam int rfaw   = 6;    // register index width

   // plain vector types
   typedef logic [pkt_w-1:0]  packet_t;
   typedef logic [addr_w-1:0] addr_t;
   typedef logic [data_w-1:0] data_t;
   typedef logic [15:0]       clk_cfg_t;   // pll settings
   typedef logic [11:0]       chipid_t;
   typedef logic [rfaw-1:0]   reg_idx_t;   // taken from addr[7:2]

   //########################################
   // packet layout, msb first
   //########################################
   typedef struct packed {
      addr_t       srcaddr;   // return address for reads
      data_t       data;
      addr_t       dstaddr;
      logic [4:0]  ctrlmode;
      logic [1:0]  datamode;
      logic        write;     // lsb of the packet
   } emesh_pkt_t;

   //########################################
   // config register group decode
   //########################################
   localparam logic [11:0] elink_id  = 12'h810;  // vs addr[31:20]
   localparam logic [2:0]  cfg_group = 3'd2;     // vs addr[10:8]

   // register indices within the group
   localparam reg_idx_t reg_reset  = reg_idx_t'(0);
   localparam reg_idx_t reg_clk    = reg_idx_t'(1);
   localparam reg_idx_t reg_chipid = reg_idx_t'(2);

   // values after nreset
   localparam clk_cfg_t clk_cfg_default = 16'h0573;  // all clocks on, slowest
   localparam chipid_t  chipid_default  = 12'h808;

   //########################################
   // stage to stage bundles
   //########################################
   // stage 1 result, fields split out
   typedef struct packed {
      logic       access;
      emesh_pkt_t pkt;
   } access_t;

   // stage 2 result, config writes already filtered
   typedef struct packed {
      logic    access;
      packet_t packet;
   } tx_t;

endpackage

`default_nettype wire

//--- rtl/elink_txwr_top.sv
`timescale 1ns/1ps
`default_nettype none

// tx write config slice
// unpack -> cfg decode/filter -> soft reset gate -> fifo port
module elink_txwr_top
   import elink_pkg::*;
(
   input  wire          clk,
   input  wire          nreset,             // por, async active low
   // mesh write input
   input  wire          txwr_access,
   input  wire packet_t txwr_packet,
   // toward the tx fifo
   output logic         txwr_gated_access,
   output packet_t      txwr_gated_packet,
   // config outputs
   output logic         etx_soft_reset,
   output logic         erx_soft_reset,
   output clk_cfg_t     clk_config,         // pll settings
   output chipid_t      chipid
);

   access_t s1;  // stage 1 -> 2
   tx_t     s2;  // stage 2 -> 3

   //########################################
   // pipeline
   //########################################
   emesh_unpack i_unpack (
      .clk         (clk),
      .nreset      (nreset),
      .txwr_access (txwr_access),
      .txwr_packet (txwr_packet),
      .s1          (s1)
   );

   elink_cfg i_cfg (
      .clk            (clk),
      .nreset         (nreset),
      .s1             (s1),
      .s2             (s2),
      .etx_soft_reset (etx_soft_reset),  // also feeds the gate
      .erx_soft_reset (erx_soft_reset),
      .clk_config     (clk_config),
      .chipid         (chipid)
   );

   etx_gate i_gate (
      .clk               (clk),
      .nreset            (nreset),
      .s2                (s2),
      .etx_soft_reset    (etx_soft_reset),
      .txwr_gated_access (txwr_gated_access),
      .txwr_gated_packet (txwr_gated_packet)
   );

endmodule

`default_nettype wire

//--- rtl/emesh_unpack.sv
`timescale 1ns/1ps
`default_nettype none

// stage 1 of the tx write path
// samples the strobe and splits the raw packet into mesh fields
module emesh_unpack
   import elink_pkg::*;
(
   input  wire          clk,
   input  wire          nreset,       // async, active low
   input  wire          txwr_access,  // one cycle per packet
   input  wire packet_t txwr_packet,
   output access_t      s1            // to the decoder
);

   logic       access_q;   // registered strobe
   emesh_pkt_t pkt_view;   // incoming packet as fields
   emesh_pkt_t pkt_q;      // held fields

   //########################################
   // field view
   //########################################
   // same width, so this is a pure re-label of the bits
   assign pkt_view = emesh_pkt_t'(txwr_packet);

   //########################################
   // strobe register
   //########################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         access_q <= 1'b0;
      end else begin
         access_q <= txwr_access;  // no back-pressure, take every cycle
      end
   end

   //########################################
   // packet register
   //########################################
   // only moves on a real access
   // fields stay put between packets for the decoder
   always_ff @(posedge clk) begin
      if (txwr_access) begin
         pkt_q <= pkt_view;
      end
   end

   // bundle for stage 2
   assign s1.access = access_q;
   assign s1.pkt    = pkt_q;

endmodule

`default_nettype wire

//--- rtl/etx_gate.sv
`timescale 1ns/1ps
`default_nettype none

// stage 3 of the tx write path
// last register before the tx fifo port
module etx_gate
   import elink_pkg::*;
(
   input  wire          clk,
   input  wire          nreset,             // async, active low
   input  wire tx_t     s2,                 // filtered stream
   input  wire          etx_soft_reset,     // from the reset register
   output logic         txwr_gated_access,  // fifo write strobe
   output packet_t      txwr_gated_packet   // fifo write data
);

   logic fwd;  // packet actually goes to the fifo

   //########################################
   // soft reset gate
   //########################################
   // traffic reaching this stage while tx is held in soft reset is lost
   // rather than stalled, there is nowhere to park it
   assign fwd = s2.access & ~etx_soft_reset;

   //########################################
   // fifo port registers
   //########################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         txwr_gated_access <= 1'b0;
      end else begin
         txwr_gated_access <= fwd;  // one cycle pulse per packet
      end
   end

   // data only changes with a forwarded strobe
   // dropped packets leave the last good one on the port
   always_ff @(posedge clk) begin
      if (fwd) begin
         txwr_gated_packet <= s2.packet;
      end
   end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the tx write testbench with verilator

verilator --binary --timing --assert -f tb.f --top-module tb_elink_txwr -o sim_tb \
   || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim_tb 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Finished with no errors" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- tb.f
rtl/elink_pkg.sv
rtl/emesh_unpack.sv
rtl/elink_cfg.sv
rtl/etx_gate.sv
rtl/elink_txwr_top.sv
test/elink_txwr_checker.sv
test/tb_elink_txwr.sv

//--- test/elink_txwr_checker.sv
`timescale 1ns/1ps
`default_nettype none

// protocol assertions on the tx write slice
module elink_txwr_checker (
   input wire clk,
   input wire nreset,
   input wire txwr_access,
   input wire txwr_gated_access,
   input wire etx_soft_reset,
   input wire erx_soft_reset
);

   //########################################
   // fifo port
   //########################################
   // gate register saw the soft reset on the edge that set the strobe
   property no_strobe_in_soft_reset;
      @(posedge clk) disable iff (!nreset)
         $past(etx_soft_reset) |-> !txwr_gated_access;
   endproperty

   // three register stages from input to fifo
   property strobe_has_source;
      @(posedge clk) disable iff (!nreset)
         txwr_gated_access |-> $past(txwr_access, 3);
   endproperty

   //########################################
   // soft resets
   //########################################
   // one edge into reset, registers are cleared
   property soft_resets_low_in_reset;
      @(posedge clk)
         (!nreset && $past(!nreset)) |-> (!etx_soft_reset && !erx_soft_reset);
   endproperty

   a_no_strobe_in_soft_reset : assert property (no_strobe_in_soft_reset)
      else $error("gated strobe while tx soft reset was set");
   a_strobe_has_source : assert property (strobe_has_source)
      else $error("gated strobe without an input strobe three cycles earlier");
   a_soft_resets_low : assert property (soft_resets_low_in_reset)
      else $error("soft reset level high during nreset");

endmodule

bind elink_txwr_top elink_txwr_checker i_checker (
   .clk               (clk),
   .nreset            (nreset),
   .txwr_access       (txwr_access),
   .txwr_gated_access (txwr_gated_access),
   .etx_soft_reset    (etx_soft_reset),
   .erx_soft_reset    (erx_soft_reset)
);

`default_nettype wire

//--- test/tb_elink_txwr.sv
`timescale 1ns/1ps
`default_nettype none

// table driven testbench for the tx write config slice
module tb_elink_txwr
   import elink_pkg::*;
();

   logic     clk;
   logic     nreset;
   logic     txwr_access;
   packet_t  txwr_packet;
   logic     txwr_gated_access;
   packet_t  txwr_gated_packet;
   logic     etx_soft_reset;
   logic     erx_soft_reset;
   clk_cfg_t clk_config;
   chipid_t  chipid;

   // stimulus table, one entry per cycle
   string t_name[$];
   logic  t_access[$];
   addr_t t_addr[$];
   logic  t_write[$];
   data_t t_data[$];
   logic  t_rand[$];    // data taken from the generator

   // reference model results, one per driven cycle
   string    exp_name[$];
   logic     exp_acc[$];     // strobe at the fifo port 3 cycles later
   packet_t  exp_pkt[$];
   logic     exp_tx[$];      // register state 2 cycles later
   logic     exp_rx[$];
   clk_cfg_t exp_clk[$];
   chipid_t  exp_chip[$];

   // model state
   logic     ref_tx;
   logic     ref_rx;
   clk_cfg_t ref_clk;
   chipid_t  ref_chip;

   logic [31:0] rng_state;
   int          n_checks;
   int          n_errors;
   logic        released;

   elink_txwr_top i_dut (
      .clk               (clk),
      .nreset            (nreset),
      .txwr_access       (txwr_access),
      .txwr_packet       (txwr_packet),
      .txwr_gated_access (txwr_gated_access),
      .txwr_gated_packet (txwr_gated_packet),
      .etx_soft_reset    (etx_soft_reset),
      .erx_soft_reset    (erx_soft_reset),
      .clk_config        (clk_config),
      .chipid            (chipid)
   );

   always #20 clk = ~clk;  // 40 ns period

   //########################################
   // helpers
   //########################################
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // link 0x810, group 2, word index
   function automatic addr_t cfg_addr(input logic [5:0] idx);
      return {12'h810, 9'h000, 3'd2, idx, 2'b00};
   endfunction

   task automatic add_entry(input string name, input logic acc, input addr_t addr,
                            input logic wr, input data_t data, input logic rnd);
      t_name.push_back(name);
      t_access.push_back(acc);
      t_addr.push_back(addr);
      t_write.push_back(wr);
      t_data.push_back(data);
      t_rand.push_back(rnd);
   endtask

   //########################################
   // compare tasks
   //########################################
   task automatic check_packet(input string name, input packet_t exp, input packet_t act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("** Error %s: txwr_gated_packet expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_clk_cfg(input string name, input clk_cfg_t exp, input clk_cfg_t act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("** Error %s: clk_config expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_chipid(input string name, input chipid_t exp, input chipid_t act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("** Error %s: chipid expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input string sig, input logic exp,
                            input logic act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("** Error %s: %s expected %b actual %b", name, sig, exp, act);
      end
   endtask

   //########################################
   // reference model
   //########################################
   // bit positions: write 0, dstaddr 39:8, data 71:40
   task automatic predict(input string name, input logic acc, input packet_t pkt);
      addr_t      dst;
      data_t      data;
      logic [5:0] idx;
      logic       hit;
      logic       regwr;
      dst   = pkt[39:8];
      data  = pkt[71:40];
      idx   = dst[7:2];
      hit   = acc && (dst[31:20] == 12'h810) && (dst[10:8] == 3'd2);
      regwr = hit && pkt[0] && (idx <= 6'd2);  // only three real registers
      if (regwr) begin
         case (idx)
            6'd0: begin
               ref_tx = data[0];
               ref_rx = data[1];
            end
            6'd1: ref_clk = data[15:0];
            default: ref_chip = data[11:0];
         endcase
      end
      exp_name.push_back(name);
      // tx reset written by this or any earlier entry blocks the packet
      exp_acc.push_back(acc && !regwr && !ref_tx);
      exp_pkt.push_back(pkt);
      exp_tx.push_back(ref_tx);
      exp_rx.push_back(ref_rx);
      exp_clk.push_back(ref_clk);
      exp_chip.push_back(ref_chip);
   endtask

   //########################################
   // stimulus
   //########################################
   task automatic build_table();
      addr_t other_link;
      addr_t other_group;
      other_link  = {12'h820, 9'h000, 3'd2, 6'd1, 2'b00};
      other_group = {12'h810, 9'h000, 3'd3, 6'd1, 2'b00};
      add_entry("clk_write",       1'b1, cfg_addr(6'd1), 1'b1, 32'h0000_0a5c, 1'b0);
      add_entry("idle",            1'b0, 32'h0,          1'b0, 32'h0,         1'b0);
      add_entry("chipid_write",    1'b1, cfg_addr(6'd2), 1'b1, 32'hffff_f123, 1'b0);
      add_entry("clk_write_rand",  1'b1, cfg_addr(6'd1), 1'b1, 32'h0,         1'b1);
      // back to back traffic outside the registers
      add_entry("plain_write",     1'b1, 32'h8200_0040,  1'b1, 32'h0,         1'b1);
      add_entry("plain_read",      1'b1, 32'h0010_0004,  1'b0, 32'h0,         1'b1);
      add_entry("other_link",      1'b1, other_link,     1'b1, 32'h0,         1'b1);
      add_entry("other_group",     1'b1, other_group,    1'b1, 32'h0,         1'b1);
      add_entry("unused_index",    1'b1, cfg_addr(6'd5), 1'b1, 32'h0,         1'b1);
      add_entry("no_strobe_cfg",   1'b0, cfg_addr(6'd1), 1'b1, 32'h0000_dead, 1'b0);
      // tx soft reset on, then off again
      add_entry("before_tx_reset", 1'b1, 32'h8200_0080,  1'b1, 32'h0,         1'b1);
      add_entry("tx_reset_on",     1'b1, cfg_addr(6'd0), 1'b1, 32'h0000_0001, 1'b0);
      add_entry("dropped_write",   1'b1, 32'h8200_00c0,  1'b1, 32'h0,         1'b1);
      add_entry("dropped_read",    1'b1, 32'h0010_0008,  1'b0, 32'h0,         1'b1);
      add_entry("cfg_in_reset",    1'b1, cfg_addr(6'd2), 1'b1, 32'h0000_0456, 1'b0);
      add_entry("tx_reset_off",    1'b1, cfg_addr(6'd0), 1'b1, 32'h0000_0002, 1'b0);
      add_entry("flow_again",      1'b1, 32'h8200_0100,  1'b1, 32'h0,         1'b1);
      add_entry("flow_again_2",    1'b1, 32'h8200_0104,  1'b1, 32'h0,         1'b1);
      // reads of the registers go to the fifo
      add_entry("cfg_read_clk",    1'b1, cfg_addr(6'd1), 1'b0, 32'h0,         1'b1);
      add_entry("cfg_read_chipid", 1'b1, cfg_addr(6'd2), 1'b0, 32'h0,         1'b1);
      add_entry("cfg_read_reset",  1'b1, cfg_addr(6'd0), 1'b0, 32'h0,         1'b1);
      add_entry("rx_reset_clear",  1'b1, cfg_addr(6'd0), 1'b1, 32'h0000_0000, 1'b0);
      add_entry("last_write",      1'b1, 32'h8200_0200,  1'b1, 32'h0,         1'b1);
   endtask

   // drive one table row, or idle past the end
   task automatic drive_entry(input int k);
      data_t   data;
      packet_t pkt;
      if (k < t_name.size()) begin
         data = t_data[k];
         if (t_rand[k]) begin
            rng_state = xorshift32(rng_state);
            data      = rng_state;
         end
         pkt = {32'h0000_1000 + 32'(k), data, t_addr[k], 5'h00, 2'b10, t_write[k]};
         txwr_access = t_access[k];
         txwr_packet = pkt;
         predict(t_name[k], t_access[k], pkt);
      end else begin
         txwr_access = 1'b0;  // packet lines keep their last value
         predict("drain", 1'b0, txwr_packet);
      end
   endtask

   // outputs of earlier rows, seen at this falling edge
   task automatic check_outputs(input int step);
      int k;
      if (step >= 3) begin
         k = step - 3;
         check_bit(exp_name[k], "txwr_gated_access", exp_acc[k], txwr_gated_access);
         if (exp_acc[k]) begin
            check_packet(exp_name[k], exp_pkt[k], txwr_gated_packet);
         end
      end else begin
         check_bit("pipeline_fill", "txwr_gated_access", 1'b0, txwr_gated_access);
      end
      if (step >= 2) begin
         k = step - 2;
         check_bit(exp_name[k], "etx_soft_reset", exp_tx[k], etx_soft_reset);
         check_bit(exp_name[k], "erx_soft_reset", exp_rx[k], erx_soft_reset);
         check_clk_cfg(exp_name[k], exp_clk[k], clk_config);
         check_chipid(exp_name[k], exp_chip[k], chipid);
      end
   endtask

   task automatic wait_reset_release(output logic ok);
      int cycles;
      cycles = 0;
      while (nreset !== 1'b1 && cycles < 20) begin
         @(negedge clk);
         cycles++;
      end
      ok = (nreset === 1'b1);
   endtask

   //########################################
   // reset
   //########################################
   initial begin
      repeat (4) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;
   end

   //########################################
   // main sequence
   //########################################
   initial begin
      clk         = 1'b0;
      nreset      = 1'b0;
      txwr_access = 1'b0;
      txwr_packet = '0;
      rng_state   = 32'd71;
      n_checks    = 0;
      n_errors    = 0;
      ref_tx      = 1'b0;
      ref_rx      = 1'b0;
      ref_clk     = 16'h0573;
      ref_chip    = 12'h808;
      build_table();

      wait_reset_release(released);
      if (!released) begin
         $display("timeout: nreset never went high");
         n_errors++;
      end else begin
         // values right after reset
         check_clk_cfg("reset_values", 16'h0573, clk_config);
         check_chipid("reset_values", 12'h808, chipid);
         check_bit("reset_values", "etx_soft_reset", 1'b0, etx_soft_reset);
         check_bit("reset_values", "erx_soft_reset", 1'b0, erx_soft_reset);
         check_bit("reset_values", "txwr_gated_access", 1'b0, txwr_gated_access);
         for (int step = 0; step < t_name.size() + 3; step++) begin
            @(negedge clk);
            check_outputs(step);
            drive_entry(step);
         end
      end

      $display("checks: %0d  errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire
